//--- include/pixPack_defines.svh
`ifndef PIXPACK_DEFINES_SVH
`define PIXPACK_DEFINES_SVH

// Width of one packed output word
`define PIX_WORD_W 32

// Default number of words buffered on the output side, power of two
`define PIX_FIFO_DEPTH 16

`endif

//--- rtl/pixPackPkg.sv
package pixPackPkg;

	// Pixel packing format as seen on i_format
	//   FMT_4BIT  : R[7:4] only, eight pixels per word
	//   FMT_8BIT  : R byte, four pixels per word
	//   FMT_24BIT : R,G,B byte stream, four pixels per three words
	//   FMT_15BIT : 5-5-5 plus mask bit, two pixels per word
	typedef enum logic [1:0]
	{
		FMT_4BIT  = 2'd0,
		FMT_8BIT  = 2'd1,
		FMT_24BIT = 2'd2,
		FMT_15BIT = 2'd3
	} pixFormat_e;

endpackage

//--- rtl/pixCapture.sv
`timescale 1ns/100ps

module pixCapture
	import pixPackPkg::*;
(
	input  logic       i_clk,
	input  logic       i_nrst,
	input  logic       i_frameStart,

	// Pixel source side
	input  logic       i_pixValid,
	output logic       o_pixReady,
	input  logic [7:0] i_r,
	input  logic [7:0] i_g,
	input  logic [7:0] i_b,
	input  pixFormat_e i_format,
	input  logic       i_maskBit,

	// Packer side
	output logic       o_capValid,
	input  logic       i_packReady,
	output logic [7:0] o_r,
	output logic [7:0] o_g,
	output logic [7:0] o_b,
	output logic       o_maskBit
);
	logic capValid;
	logic accept;
	logic isColour;

	// Ready when the holding register is empty or drains this cycle
	assign o_pixReady = !capValid || i_packReady;
	assign accept     = i_pixValid && o_pixReady;
	assign o_capValid = capValid;

	// Grey formats only look at red, so G and B stay put then
	assign isColour = (i_format == FMT_15BIT) || (i_format == FMT_24BIT);

	always_ff @(posedge i_clk)
	begin
		if (!i_nrst)
			capValid <= 1'b0;
		else if (i_frameStart)
			capValid <= 1'b0;
		else if (accept)
			capValid <= 1'b1;
		else if (i_packReady)
			capValid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			o_r <= i_r;
			if (isColour)
			begin
				o_g <= i_g;
				o_b <= i_b;
			end
			if (i_format == FMT_15BIT)
				o_maskBit <= i_maskBit;
		end
	end

endmodule

//--- rtl/pixPacker.sv
`timescale 1ns/100ps

`include "pixPack_defines.svh"

module pixPacker
	import pixPackPkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  logic                   i_frameStart,
	input  pixFormat_e             i_format,

	// Held pixel from the capture register
	input  logic                   i_capValid,
	output logic                   o_packReady,
	input  logic [7:0]             i_r,
	input  logic [7:0]             i_g,
	input  logic [7:0]             i_b,
	input  logic                   i_maskBit,

	// Word write port into the FIFO
	output logic                   o_wrEn,
	output logic [`PIX_WORD_W-1:0] o_wrData,
	input  logic                   i_fifoFull
);
	localparam int NIB_N = `PIX_WORD_W / 4;

	logic [2:0]             pixCnt;
	logic [`PIX_WORD_W-1:0] acc;
	logic [15:0]            carry;
	logic                   consume;
	logic                   complete;
	logic                   useCarry;
	logic [NIB_N-1:0]       nibMask;
	logic [`PIX_WORD_W-1:0] fillWord;
	logic [`PIX_WORD_W-1:0] baseWord;
	logic [`PIX_WORD_W-1:0] merged;
	logic [15:0]            px15;

	// Spread a per-nibble select into a per-bit select
	function automatic logic [`PIX_WORD_W-1:0] nibToBits(input logic [NIB_N-1:0] m);
		logic [`PIX_WORD_W-1:0] bits;
		bits = '0;
		for (int i = 0; i < NIB_N; i++)
			bits[4*i +: 4] = {4{m[i]}};
		return bits;
	endfunction

	// A word is written in the same cycle its last pixel is taken,
	// so a full FIFO simply stalls the pixel
	assign o_packReady = !i_fifoFull;

	// A frame start drops whatever pixel is held at that moment
	assign consume = i_capValid && o_packReady && !i_frameStart;

	// 5-5-5 colour with the mask bit at the bottom
	assign px15 = {i_r[7:3], i_g[7:3], i_b[7:3], i_maskBit};

	// Nibble slots hit by this pixel and the value offered to them
	always_comb
	begin
		nibMask  = '0;
		fillWord = '0;
		complete = 1'b0;
		case (i_format)
			FMT_4BIT:
			begin
				nibMask  = 8'h80 >> pixCnt;
				fillWord = {8{i_r[7:4]}};
				complete = (pixCnt == 3'd7);
			end
			FMT_8BIT:
			begin
				nibMask  = 8'hC0 >> {pixCnt[1:0], 1'b0};
				fillWord = {4{i_r}};
				complete = (pixCnt[1:0] == 2'd3);
			end
			FMT_15BIT:
			begin
				nibMask  = pixCnt[0] ? 8'h0F : 8'hF0;
				fillWord = {2{px15}};
				complete = pixCnt[0];
			end
			FMT_24BIT:
			begin
				// Byte stream R0 G0 B0 R1 | G1 B1 R2 G2 | B2 R3 G3 B3
				case (pixCnt[1:0])
					2'd0:
					begin
						nibMask  = 8'hFC;
						fillWord = {i_r, i_g, i_b, 8'h00};
					end
					2'd1:
					begin
						nibMask  = 8'h03;
						fillWord = {24'h0, i_r};
					end
					2'd2:
					begin
						nibMask  = 8'h0F;
						fillWord = {16'h0, i_r, i_g};
					end
					default:
					begin
						nibMask  = 8'h3F;
						fillWord = {8'h0, i_r, i_g, i_b};
					end
				endcase
				complete = (pixCnt[1:0] != 2'd0);
			end
			default:
			begin
				nibMask  = '0;
				fillWord = '0;
				complete = 1'b0;
			end
		endcase
	end

	// Third and fourth pixel of a 24-bit group start from the spilled bytes
	assign useCarry = (i_format == FMT_24BIT) && pixCnt[1];
	assign baseWord = useCarry ? {carry, 16'h0} : acc;

	assign merged = (baseWord & ~nibToBits(nibMask)) | (fillWord & nibToBits(nibMask));

	assign o_wrEn   = consume && complete;
	assign o_wrData = merged;

	always_ff @(posedge i_clk)
	begin
		if (!i_nrst)
			pixCnt <= '0;
		else if (i_frameStart)
			pixCnt <= '0;
		else if (consume)
			pixCnt <= pixCnt + 3'd1;
	end

	// Accumulator and 24-bit spill register
	always_ff @(posedge i_clk)
	begin
		if (consume)
		begin
			acc <= merged;
			if ((i_format == FMT_24BIT) && (pixCnt[1:0] == 2'd1))
				carry <= {i_g, i_b};
			else if ((i_format == FMT_24BIT) && (pixCnt[1:0] == 2'd2))
				carry <= {i_b, 8'h00};
		end
	end

endmodule

//--- rtl/wordFifo.sv
`timescale 1ns/100ps

`include "pixPack_defines.svh"

module wordFifo
#(
	parameter int DEPTH = `PIX_FIFO_DEPTH
)
(
	input  logic                   i_clk,
	input  logic                   i_nrst,

	input  logic                   i_wrEn,
	input  logic [`PIX_WORD_W-1:0] i_wrData,
	output logic                   o_full,

	input  logic                   i_rdEn,
	output logic [`PIX_WORD_W-1:0] o_rdData,
	output logic                   o_empty
);
	localparam int AW = $clog2(DEPTH);

	logic [`PIX_WORD_W-1:0] mem [DEPTH];
	logic [AW:0]            wrPtr;
	logic [AW:0]            rdPtr;
	logic                   doWrite;
	logic                   doRead;

	// Extra pointer bit tells a wrapped full buffer from an empty one
	assign o_empty = (wrPtr == rdPtr);
	assign o_full  = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);

	assign doWrite = i_wrEn && !o_full;
	assign doRead  = i_rdEn && !o_empty;

	// Head entry is always visible
	assign o_rdData = mem[rdPtr[AW-1:0]];

	always_ff @(posedge i_clk)
	begin
		if (doWrite)
			mem[wrPtr[AW-1:0]] <= i_wrData;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
		end
	end

endmodule

//--- rtl/pixPackTop.sv
`timescale 1ns/100ps

`include "pixPack_defines.svh"

module pixPackTop
	import pixPackPkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  logic                   i_frameStart,

	input  logic                   i_pixValid,
	output logic                   o_pixReady,
	input  logic [7:0]             i_r,
	input  logic [7:0]             i_g,
	input  logic [7:0]             i_b,
	input  pixFormat_e             i_format,
	input  logic                   i_maskBit,

	output logic                   o_wordValid,
	input  logic                   i_wordReady,
	output logic [`PIX_WORD_W-1:0] o_wordData
);
	logic                   capValid;
	logic                   packReady;
	logic [7:0]             capR;
	logic [7:0]             capG;
	logic [7:0]             capB;
	logic                   capMask;
	logic                   wrEn;
	logic [`PIX_WORD_W-1:0] wrData;
	logic                   fifoFull;
	logic                   fifoEmpty;
	logic                   rdEn;

	pixCapture u_capture
	(
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_frameStart (i_frameStart),
		.i_pixValid   (i_pixValid),
		.o_pixReady   (o_pixReady),
		.i_r          (i_r),
		.i_g          (i_g),
		.i_b          (i_b),
		.i_format     (i_format),
		.i_maskBit    (i_maskBit),
		.o_capValid   (capValid),
		.i_packReady  (packReady),
		.o_r          (capR),
		.o_g          (capG),
		.o_b          (capB),
		.o_maskBit    (capMask)
	);

	// Format is stable per frame and goes to the packer directly
	pixPacker u_packer
	(
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_frameStart (i_frameStart),
		.i_format     (i_format),
		.i_capValid   (capValid),
		.o_packReady  (packReady),
		.i_r          (capR),
		.i_g          (capG),
		.i_b          (capB),
		.i_maskBit    (capMask),
		.o_wrEn       (wrEn),
		.o_wrData     (wrData),
		.i_fifoFull   (fifoFull)
	);

	wordFifo #(.DEPTH(`PIX_FIFO_DEPTH)) u_fifo
	(
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_wrEn       (wrEn),
		.i_wrData     (wrData),
		.o_full       (fifoFull),
		.i_rdEn       (rdEn),
		.o_rdData     (o_wordData),
		.o_empty      (fifoEmpty)
	);

	assign o_wordValid = !fifoEmpty;
	assign rdEn        = o_wordValid && i_wordReady;

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/100ps

module tbClock
#(
	parameter real PERIOD = 4.0
)
(
	output logic o_clk
);
	initial
		o_clk = 1'b0;

	always
		#(PERIOD / 2.0) o_clk = ~o_clk;

endmodule

//--- testbench/pixPackTb.sv
`timescale 1ns/100ps

`include "pixPack_defines.svh"

module pixPackTb
	import pixPackPkg::*;
();
	typedef struct packed
	{
		pixFormat_e fmt;
		logic [7:0] count;
		logic       mask;
		logic [7:0] stall;
	} caseRow_t;

	localparam int NUM_CASES = 11;

	// Format, pixel count, mask bit, sink stall length in cycles (0 = never stalls)
	localparam caseRow_t CASE_TAB [NUM_CASES] = '{
		'{FMT_4BIT,  8'd16, 1'b0, 8'd0},
		'{FMT_8BIT,  8'd8,  1'b0, 8'd0},
		'{FMT_15BIT, 8'd8,  1'b0, 8'd0},
		'{FMT_15BIT, 8'd8,  1'b1, 8'd3},
		'{FMT_24BIT, 8'd8,  1'b0, 8'd0},
		'{FMT_24BIT, 8'd64, 1'b1, 8'd40},
		'{FMT_4BIT,  8'd13, 1'b0, 8'd0},
		'{FMT_8BIT,  8'd6,  1'b0, 8'd2},
		'{FMT_24BIT, 8'd10, 1'b0, 8'd0},
		'{FMT_15BIT, 8'd9,  1'b1, 8'd0},
		'{FMT_8BIT,  8'd96, 1'b0, 8'd80}
	};

	logic                   clk;
	logic                   nrst;
	logic                   frameStart;
	logic                   pixValid;
	logic                   pixReady;
	logic [7:0]             r;
	logic [7:0]             g;
	logic [7:0]             b;
	pixFormat_e             format;
	logic                   maskBit;
	logic                   wordValid;
	logic                   wordReady;
	logic [`PIX_WORD_W-1:0] wordData;

	logic [31:0]            rngState;
	logic [3:0]             nibQ [$];
	logic [`PIX_WORD_W-1:0] expQ [$];
	int                     errCount = 0;
	int                     wordCount = 0;
	int                     blockedCycles = 0;
	int                     stallLen = 0;
	int                     sinkCyc = 0;

	tbClock u_clock
	(
		.o_clk (clk)
	);

	pixPackTop u_dut
	(
		.i_clk        (clk),
		.i_nrst       (nrst),
		.i_frameStart (frameStart),
		.i_pixValid   (pixValid),
		.o_pixReady   (pixReady),
		.i_r          (r),
		.i_g          (g),
		.i_b          (b),
		.i_format     (format),
		.i_maskBit    (maskBit),
		.o_wordValid  (wordValid),
		.i_wordReady  (wordReady),
		.o_wordData   (wordData)
	);

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			errCount++;
			$display("FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	// Nibble stream model, every eight nibbles make one word, first nibble on top
	task automatic modelPixel(input pixFormat_e fmt, input logic [7:0] pr,
		input logic [7:0] pg, input logic [7:0] pb, input logic pm);
		logic [15:0] px;
		logic [31:0] word;
		int          i;
		px = {pr[7:3], pg[7:3], pb[7:3], pm};
		case (fmt)
			FMT_4BIT:
				nibQ.push_back(pr[7:4]);
			FMT_8BIT:
			begin
				nibQ.push_back(pr[7:4]);
				nibQ.push_back(pr[3:0]);
			end
			FMT_15BIT:
			begin
				for (i = 3; i >= 0; i--)
					nibQ.push_back(px[4*i +: 4]);
			end
			default:
			begin
				nibQ.push_back(pr[7:4]);
				nibQ.push_back(pr[3:0]);
				nibQ.push_back(pg[7:4]);
				nibQ.push_back(pg[3:0]);
				nibQ.push_back(pb[7:4]);
				nibQ.push_back(pb[3:0]);
			end
		endcase
		while (nibQ.size() >= 8)
		begin
			word = '0;
			for (i = 0; i < 8; i++)
				word = {word[27:0], nibQ.pop_front()};
			expQ.push_back(word);
		end
	endtask

	// Called on a rising edge, returns on the edge where the pixel is taken
	task automatic sendPixel(input logic [7:0] pr, input logic [7:0] pg,
		input logic [7:0] pb, input logic pm);
		pixValid <= 1'b1;
		r        <= pr;
		g        <= pg;
		b        <= pb;
		maskBit  <= pm;
		@(posedge clk);
		while (!pixReady)
		begin
			blockedCycles++;
			@(posedge clk);
		end
	endtask

	// Once all expected words are out the FIFO has room and capture empties
	task automatic waitDrain();
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
	endtask

	task automatic runCase(input caseRow_t row);
		int n;
		waitDrain();
		stallLen      = row.stall;
		blockedCycles = 0;
		// Leftover nibbles of a partial word are dropped by the frame start
		nibQ.delete();
		format     <= row.fmt;
		frameStart <= 1'b1;
		@(posedge clk);
		frameStart <= 1'b0;
		for (n = 0; n < row.count; n++)
		begin
			rngState = nextRandom(rngState);
			modelPixel(row.fmt, rngState[7:0], rngState[15:8], rngState[23:16], row.mask);
			sendPixel(rngState[7:0], rngState[15:8], rngState[23:16], row.mask);
		end
		pixValid <= 1'b0;
		if ((row.stall >= 16) && (blockedCycles == 0))
		begin
			errCount++;
			$display("Input ready never dropped while the sink stalled for %0d cycles",
				row.stall);
		end
	endtask

	// Sink with a stall pattern that restarts on every frame start
	initial
	begin
		wordReady = 1'b0;
		wait (nrst === 1'b1);
		forever
		begin
			@(posedge clk);
			if (wordValid && wordReady)
			begin
				if (expQ.size() == 0)
				begin
					errCount++;
					$display("Extra word 0x%h at %0t ns with no pixels left to form it",
						wordData, $time);
				end
				else
					compareValue("o_wordData", wordData, expQ.pop_front());
				wordCount++;
			end
			if (frameStart)
				sinkCyc = 0;
			else
				sinkCyc++;
			wordReady <= (stallLen == 0) || ((sinkCyc % (2 * stallLen)) >= stallLen);
		end
	end

	initial
	begin : watchdog
		int limit;
		int k;
		limit = 1000;
		for (k = 0; k < NUM_CASES; k++)
			limit += 50 * CASE_TAB[k].count;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin : mainSeq
		int k;
		nrst       = 1'b0;
		frameStart = 1'b0;
		pixValid   = 1'b0;
		r          = 8'h00;
		g          = 8'h00;
		b          = 8'h00;
		format     = FMT_4BIT;
		maskBit    = 1'b0;
		rngState   = 32'hed952e37;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);
		compareValue("o_pixReady", 32'(pixReady), 32'd1);
		compareValue("o_wordValid", 32'(wordValid), 32'd0);

		for (k = 0; k < NUM_CASES; k++)
			runCase(CASE_TAB[k]);

		// Free-running sink, any stray word would show up here
		stallLen = 0;
		waitDrain();
		repeat (40) @(posedge clk);
		compareValue("o_wordValid", 32'(wordValid), 32'd0);

		$display("Errors: %0d, words checked: %0d", errCount, wordCount);
		if (errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
rtl/pixPackPkg.sv
rtl/pixCapture.sv
rtl/pixPacker.sv
rtl/wordFifo.sv
rtl/pixPackTop.sv
testbench/tbClock.sv
testbench/pixPackTb.sv

//--- Makefile
# Verilator build of the pixel packer testbench
VERILATOR ?= verilator
TOP       ?= pixPackTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal --timescale 1ns/100ps
PASS_TEXT ?= Simulation finished: PASS

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
